// File: hdl/sq_cfg_pkg.sv
`default_nettype none

package sq_cfg_pkg;

   // queue geometry
   localparam int DEFAULT_DEPTH = 16;

   // field widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 16;
   localparam int ROB_IDX_W = 7;
   localparam int LD_IDX_W = 6; // low bits of the reorder index

   // memory address of a store
   typedef logic [ADDR_W-1:0] addr_t;

   // store data sent to the cache
   typedef logic [DATA_W-1:0] data_t;

   // reorder index, also the age of a store
   typedef logic [ROB_IDX_W-1:0] rob_idx_t;

   // index presented by the load/store unit on an update
   typedef logic [LD_IDX_W-1:0] ld_idx_t;

endpackage

`default_nettype wire

// File: hdl/sq_ctrl_pkg.sv
`default_nettype none

package sq_ctrl_pkg;

   localparam int ALLOC_SLOTS = 4; // stores allocated per cycle

   // drain FSM of the head store
   typedef enum logic [1:0] {
      IDLE       = 2'b00,
      WAIT_GRANT = 2'b01, // str_req held until granted
      ISSUED     = 2'b10, // waiting for str_done
      WAIT_WRITE = 2'b11  // head address and data not yet in
   } commit_state_t;

endpackage

`default_nettype wire

// File: hdl/sq_entry_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sq_entry_if #(
   parameter int DEPTH = sq_cfg_pkg::DEFAULT_DEPTH
);
   import sq_cfg_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   logic [DEPTH-1:0] free;    // 1 = entry empty
   logic [DEPTH-1:0] written; // address and data valid
   rob_idx_t idx [DEPTH];
   addr_t addr [DEPTH];
   data_t data [DEPTH];
   logic [PTR_W-1:0] head;    // oldest store

   // entry storage drives everything
   modport owner (output free, written, idx, addr, data, head);

   // commit side only needs the head entry
   modport drain (input head, written, addr, data);

   // forwarding looks at the whole array
   modport search (input free, written, idx, addr, data, head);

endinterface

`default_nettype wire

// File: hdl/sq_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

module sq_entry_array #(
   parameter int DEPTH = sq_cfg_pkg::DEFAULT_DEPTH
) (
   input  wire logic                                           clk,
   input  wire logic                                           rst,
   input  wire logic [sq_ctrl_pkg::ALLOC_SLOTS-1:0]            alloc_vld,
   input  wire sq_cfg_pkg::rob_idx_t [sq_ctrl_pkg::ALLOC_SLOTS-1:0] alloc_idx,
   input  wire logic                                           flush,
   input  wire logic [$clog2(DEPTH)-1:0]                       flush_ptr,
   input  wire logic                                           upd_vld,
   input  wire sq_cfg_pkg::ld_idx_t                            upd_idx,
   input  wire sq_cfg_pkg::addr_t                              upd_addr,
   input  wire sq_cfg_pkg::data_t                              upd_data,
   input  wire logic                                           retire,
   output logic                                                stall,
   sq_entry_if.owner                                           ent
);
   import sq_cfg_pkg::*;
   import sq_ctrl_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);
   localparam int SLOT_W = $clog2(ALLOC_SLOTS);
   localparam int CNT_W = $clog2(ALLOC_SLOTS + 1);

   logic [DEPTH-1:0] free_q;
   logic [DEPTH-1:0] written_q;
   rob_idx_t idx_q [DEPTH];
   addr_t addr_q [DEPTH];
   data_t data_q [DEPTH];
   logic [PTR_W-1:0] head_q;
   logic [PTR_W-1:0] tail_q;

   logic [ALLOC_SLOTS-1:0] vld_inc;
   logic alloc_ok;
   logic [ALLOC_SLOTS-1:0] slot_en;
   logic [CNT_W-1:0] n_alloc;
   logic [PTR_W-1:0] slot_ptr;
   logic [DEPTH-1:0] alloc_hit;
   logic [SLOT_W-1:0] alloc_sel [DEPTH];
   logic [DEPTH-1:0] upd_hit;
   logic [DEPTH-1:0] retire_hit;
   logic [PTR_W-1:0] flush_span;
   logic [PTR_W-1:0] flush_off;
   logic [DEPTH-1:0] flush_mask;

   // only 0001, 0011, 0111 and 1111 allocate, nothing during a flush
   assign vld_inc = alloc_vld + 1'b1;
   assign alloc_ok = ((alloc_vld & vld_inc) == '0) & ~flush;
   assign slot_en = alloc_ok ? alloc_vld : '0;

   always_comb begin
      n_alloc = '0;
      alloc_hit = '0;
      slot_ptr = tail_q;
      for (int i = 0; i < DEPTH; i++) begin
         alloc_sel[i] = '0;
      end
      for (int s = 0; s < ALLOC_SLOTS; s++) begin
         slot_ptr = tail_q + PTR_W'(s); // wraps at DEPTH
         if (slot_en[s]) begin
            n_alloc = n_alloc + 1'b1;
            alloc_hit[slot_ptr] = 1'b1;
            alloc_sel[slot_ptr] = SLOT_W'(s);
         end
      end
   end

   assign flush_span = tail_q - flush_ptr; // entries dropped by a flush

   always_comb begin
      flush_off = '0;
      for (int i = 0; i < DEPTH; i++) begin
         upd_hit[i] = upd_vld & ~free_q[i] & (idx_q[i][$bits(ld_idx_t)-1:0] == upd_idx);
         retire_hit[i] = retire & (head_q == PTR_W'(i));
         flush_off = PTR_W'(i) - flush_ptr;
         flush_mask[i] = flush & (flush_off < flush_span);
      end
   end

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         free_q <= '1;
         written_q <= '0;
         head_q <= '0;
         tail_q <= '0;
      end else begin
         if (flush)
            tail_q <= flush_ptr;
         else
            tail_q <= tail_q + PTR_W'(n_alloc);
         if (retire)
            head_q <= head_q + 1'b1;
         for (int i = 0; i < DEPTH; i++) begin
            if (flush_mask[i]) begin
               free_q[i] <= 1'b1;
               written_q[i] <= 1'b0;
            end else if (retire_hit[i]) begin
               free_q[i] <= 1'b1;
               written_q[i] <= 1'b0;
            end else if (alloc_hit[i]) begin
               free_q[i] <= 1'b0;
               written_q[i] <= 1'b0; // new store waits for its update
            end else if (upd_hit[i]) begin
               written_q[i] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (alloc_hit[i])
            idx_q[i] <= alloc_idx[alloc_sel[i]];
         if (upd_hit[i]) begin
            addr_q[i] <= upd_addr;
            data_q[i] <= upd_data;
         end
      end
   end

   assign stall = ~free_q[tail_q]; // queue full at the tail

   assign ent.free = free_q;
   assign ent.written = written_q;
   assign ent.idx = idx_q;
   assign ent.addr = addr_q;
   assign ent.data = data_q;
   assign ent.head = head_q;

endmodule

`default_nettype wire

// File: hdl/sq_commit_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sq_commit_ctrl (
   input  wire logic          clk,
   input  wire logic          rst,
   input  wire logic          cmmt_str,
   input  wire logic          str_grnt,
   input  wire logic          str_done,
   output logic               str_req,
   output logic               str_iss,
   output logic               retire,
   output sq_cfg_pkg::addr_t  cache_addr,
   output sq_cfg_pkg::data_t  cache_data,
   sq_entry_if.drain          ent
);
   import sq_ctrl_pkg::*;

   commit_state_t state;
   commit_state_t nxt_state;
   logic head_written;

   assign head_written = ent.written[ent.head];

   // cache always sees the head entry
   assign cache_addr = ent.addr[ent.head];
   assign cache_data = ent.data[ent.head];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         state <= IDLE;
      else
         state <= nxt_state;
   end

   always_comb begin
      nxt_state = state;
      str_req = 1'b0;
      str_iss = 1'b0;
      retire = 1'b0;
      case (state)
         IDLE: begin
            if (cmmt_str)
               nxt_state = head_written ? WAIT_GRANT : WAIT_WRITE;
         end
         WAIT_WRITE: begin
            if (head_written) // update arrived late
               nxt_state = WAIT_GRANT;
         end
         WAIT_GRANT: begin
            str_req = 1'b1;
            if (str_grnt) begin
               str_iss = 1'b1;
               nxt_state = ISSUED;
            end
         end
         ISSUED: begin
            if (str_done) begin
               retire = 1'b1; // frees head, head moves on next edge
               nxt_state = IDLE;
            end
         end
         default: nxt_state = IDLE;
      endcase
   end

endmodule

`default_nettype wire

// File: hdl/sq_fwd_search.sv
`timescale 1ns/1ps
`default_nettype none

module sq_fwd_search #(
   parameter int DEPTH = sq_cfg_pkg::DEFAULT_DEPTH
) (
   input  wire sq_cfg_pkg::rob_idx_t fwd_idx,
   input  wire sq_cfg_pkg::addr_t    fwd_addr,
   output logic                      fwd_hit,
   output logic                      fwd_rdy,
   output sq_cfg_pkg::data_t         fwd_data,
   sq_entry_if.search                ent
);
   localparam int PTR_W = $clog2(DEPTH);

   logic [DEPTH-1:0] older;
   logic [DEPTH-1:0] match;
   logic [DEPTH-1:0] rot_match;
   logic [PTR_W-1:0] rot_ptr;
   logic [PTR_W-1:0] sel_off;
   logic [PTR_W-1:0] sel_ptr;

   // age and address compare per entry
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         older[i] = ~ent.free[i] & (ent.idx[i] < fwd_idx); // unsigned age
         match[i] = older[i] & (ent.addr[i] == fwd_addr);
      end
   end

   // bit 0 of rot_match is the head entry
   always_comb begin
      rot_ptr = ent.head;
      for (int k = 0; k < DEPTH; k++) begin
         rot_ptr = ent.head + PTR_W'(k);
         rot_match[k] = match[rot_ptr];
      end
   end

   // last set bit wins, i.e. the youngest older store
   always_comb begin
      sel_off = '0;
      for (int k = 0; k < DEPTH; k++) begin
         if (rot_match[k])
            sel_off = PTR_W'(k);
      end
   end

   assign sel_ptr = ent.head + sel_off;

   assign fwd_hit = |match;
   assign fwd_data = fwd_hit ? ent.data[sel_ptr] : '0;

   // every older store has its address and data
   assign fwd_rdy = &(~older | ent.written);

endmodule

`default_nettype wire

// File: hdl/store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module store_queue #(
   parameter int DEPTH = sq_cfg_pkg::DEFAULT_DEPTH
) (
   input  wire logic                                           clk,
   input  wire logic                                           rst,
   input  wire logic [sq_ctrl_pkg::ALLOC_SLOTS-1:0]            alloc_vld,
   input  wire sq_cfg_pkg::rob_idx_t [sq_ctrl_pkg::ALLOC_SLOTS-1:0] alloc_idx,
   input  wire logic                                           flush,
   input  wire logic [$clog2(DEPTH)-1:0]                       flush_ptr,
   input  wire logic                                           upd_vld,
   input  wire sq_cfg_pkg::ld_idx_t                            upd_idx,
   input  wire sq_cfg_pkg::addr_t                              upd_addr,
   input  wire sq_cfg_pkg::data_t                              upd_data,
   input  wire logic                                           cmmt_str,
   input  wire logic                                           str_grnt,
   input  wire logic                                           str_done,
   input  wire sq_cfg_pkg::rob_idx_t                           fwd_idx,
   input  wire sq_cfg_pkg::addr_t                              fwd_addr,
   output logic                                                stall,
   output logic                                                str_req,
   output logic                                                str_iss,
   output sq_cfg_pkg::addr_t                                   cache_addr,
   output sq_cfg_pkg::data_t                                   cache_data,
   output logic                                                fwd_hit,
   output logic                                                fwd_rdy,
   output sq_cfg_pkg::data_t                                   fwd_data
);
   logic retire; // head store done at the cache

   sq_entry_if #(.DEPTH(DEPTH)) ent_if ();

   sq_entry_array #(
      .DEPTH(DEPTH)
   ) entry_array_i (
      .clk       (clk),
      .rst       (rst),
      .alloc_vld (alloc_vld),
      .alloc_idx (alloc_idx),
      .flush     (flush),
      .flush_ptr (flush_ptr),
      .upd_vld   (upd_vld),
      .upd_idx   (upd_idx),
      .upd_addr  (upd_addr),
      .upd_data  (upd_data),
      .retire    (retire),
      .stall     (stall),
      .ent       (ent_if.owner)
   );

   sq_commit_ctrl commit_ctrl_i (
      .clk        (clk),
      .rst        (rst),
      .cmmt_str   (cmmt_str),
      .str_grnt   (str_grnt),
      .str_done   (str_done),
      .str_req    (str_req),
      .str_iss    (str_iss),
      .retire     (retire),
      .cache_addr (cache_addr),
      .cache_data (cache_data),
      .ent        (ent_if.drain)
   );

   sq_fwd_search #(
      .DEPTH(DEPTH)
   ) fwd_search_i (
      .fwd_idx  (fwd_idx),
      .fwd_addr (fwd_addr),
      .fwd_hit  (fwd_hit),
      .fwd_rdy  (fwd_rdy),
      .fwd_data (fwd_data),
      .ent      (ent_if.search)
   );

endmodule

`default_nettype wire

// File: sim/sq_assert.sv
`timescale 1ns/1ps
`default_nettype none

module sq_assert (
   input wire logic                       clk,
   input wire logic                       rst,
   input wire logic                       str_req,
   input wire logic                       str_iss,
   input wire logic                       str_grnt,
   input wire logic                       retire,
   input wire sq_ctrl_pkg::commit_state_t state
);
   import sq_ctrl_pkg::*;

   int fail_cnt = 0; // read by the testbench at the end

   iss_with_grant: assert property (@(posedge clk) disable iff (!rst)
      str_iss |-> (str_grnt && str_req) ##1 !str_req)
   else begin
      $error("str_iss without a granted request, or request still high after it");
      fail_cnt++;
   end

   retire_in_issued: assert property (@(posedge clk) disable iff (!rst)
      retire |-> (state == ISSUED) ##1 (state == IDLE))
   else begin
      $error("retire outside of ISSUED, or no return to IDLE after it");
      fail_cnt++;
   end

   req_low_after_reset: assert property (@(posedge clk)
      $rose(rst) |-> !str_req)
   else begin
      $error("str_req high right after reset");
      fail_cnt++;
   end

endmodule

bind sq_commit_ctrl sq_assert assert_i (.*);

`default_nettype wire

// File: sim/sq_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module sq_monitor #(
   parameter int DEPTH = sq_cfg_pkg::DEFAULT_DEPTH
) (
   input wire logic                                                 clk,
   input wire logic                                                 rst,
   input wire logic [sq_ctrl_pkg::ALLOC_SLOTS-1:0]                  alloc_vld,
   input wire sq_cfg_pkg::rob_idx_t [sq_ctrl_pkg::ALLOC_SLOTS-1:0]  alloc_idx,
   input wire logic                                                 flush,
   input wire logic [$clog2(DEPTH)-1:0]                             flush_ptr,
   input wire logic                                                 upd_vld,
   input wire sq_cfg_pkg::ld_idx_t                                  upd_idx,
   input wire sq_cfg_pkg::addr_t                                    upd_addr,
   input wire sq_cfg_pkg::data_t                                    upd_data,
   input wire logic                                                 cmmt_str,
   input wire logic                                                 str_grnt,
   input wire logic                                                 str_done,
   input wire logic                                                 str_req,
   input wire logic                                                 str_iss,
   input wire logic                                                 stall,
   input wire sq_cfg_pkg::addr_t                                    cache_addr,
   input wire sq_cfg_pkg::data_t                                    cache_data,
   input wire sq_cfg_pkg::rob_idx_t                                 fwd_idx,
   input wire sq_cfg_pkg::addr_t                                    fwd_addr,
   input wire logic                                                 fwd_hit,
   input wire logic                                                 fwd_rdy,
   input wire sq_cfg_pkg::data_t                                    fwd_data
);
   import sq_cfg_pkg::*;
   import sq_ctrl_pkg::*;

   logic m_free [DEPTH];
   logic m_written [DEPTH];
   rob_idx_t m_idx [DEPTH];
   addr_t m_addr [DEPTH];
   data_t m_data [DEPTH];
   int head;
   int tail;
   int count;              // occupied entries
   commit_state_t m_state; // expected drain state of the head store
   logic after_reset;
   int errors = 0;
   int checks = 0;

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
      end
   endtask

   // youngest older store with the load address, by reorder index
   task automatic expect_fwd(output logic hit, output data_t data, output logic rdy);
      rob_idx_t best;
      hit = 1'b0;
      data = '0;
      rdy = 1'b1;
      best = '0;
      for (int i = 0; i < DEPTH; i++) begin
         if (!m_free[i] && m_idx[i] < fwd_idx) begin
            if (!m_written[i])
               rdy = 1'b0;
            else if (m_addr[i] == fwd_addr && (!hit || m_idx[i] > best)) begin
               hit = 1'b1;
               best = m_idx[i];
               data = m_data[i];
            end
         end
      end
   endtask

   always @(negedge clk) begin : watch
      logic e_hit;
      data_t e_data;
      logic e_rdy;
      logic e_req;
      logic e_iss;
      logic e_retire;
      int n;
      int p;
      if (!rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            m_free[i] = 1'b1;
            m_written[i] = 1'b0;
         end
         head = 0;
         tail = 0;
         count = 0;
         m_state = IDLE;
         after_reset = 1'b1;
      end else begin
         if (after_reset) begin
            compare("stall after reset", stall, 0);
            compare("str_req after reset", str_req, 0);
            compare("str_iss after reset", str_iss, 0);
            compare("fwd_hit after reset", fwd_hit, 0);
            after_reset = 1'b0;
         end
         compare("stall", stall, !m_free[tail]);
         expect_fwd(e_hit, e_data, e_rdy);
         compare("fwd_rdy", fwd_rdy, e_rdy);
         if (e_rdy) begin // hit is only meaningful once every older address is known
            compare("fwd_hit", fwd_hit, e_hit);
            compare("fwd_data", fwd_data, e_data);
         end
         e_req = (m_state == WAIT_GRANT); // request held until the grant
         e_iss = e_req && str_grnt;
         e_retire = (m_state == ISSUED) && str_done;
         compare("str_req", str_req, e_req);
         compare("str_iss", str_iss, e_iss);
         if (e_iss) begin
            compare("cache_addr", cache_addr, m_addr[head]);
            compare("cache_data", cache_data, m_data[head]);
         end
         case (m_state)
            IDLE: begin
               if (cmmt_str)
                  m_state = m_written[head] ? WAIT_GRANT : WAIT_WRITE;
            end
            WAIT_WRITE: begin
               if (m_written[head])
                  m_state = WAIT_GRANT;
            end
            WAIT_GRANT: begin
               if (str_grnt)
                  m_state = ISSUED;
            end
            ISSUED: begin
               if (str_done)
                  m_state = IDLE;
            end
         endcase
         // inputs of this cycle take effect at the next rising edge
         if (upd_vld) begin
            for (int i = 0; i < DEPTH; i++) begin
               if (!m_free[i] && ld_idx_t'(m_idx[i]) == upd_idx) begin
                  m_written[i] = 1'b1;
                  m_addr[i] = upd_addr;
                  m_data[i] = upd_data;
               end
            end
         end
         if (e_retire) begin
            m_free[head] = 1'b1;
            m_written[head] = 1'b0;
            head = (head + 1) % DEPTH;
            count--;
         end
         if (flush) begin
            p = flush_ptr;
            while (p != tail) begin
               if (!m_free[p])
                  count--;
               m_free[p] = 1'b1;
               m_written[p] = 1'b0;
               p = (p + 1) % DEPTH;
            end
            tail = flush_ptr;
         end else begin
            n = 0;
            while (n < ALLOC_SLOTS && alloc_vld[n])
               n++;
            if (int'(alloc_vld) == (1 << n) - 1) begin // gaps allocate nothing
               for (int s = 0; s < n; s++) begin
                  m_free[tail] = 1'b0;
                  m_written[tail] = 1'b0;
                  m_idx[tail] = alloc_idx[s];
                  tail = (tail + 1) % DEPTH;
                  count++;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: sim/tb_store_queue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_store_queue;
   import sq_cfg_pkg::*;
   import sq_ctrl_pkg::*;

   localparam int DEPTH = 16;
   localparam int PTR_W = $clog2(DEPTH);
   localparam int RUN_CYCLES = 600;
   localparam int DRAIN_CYCLES = 600; // generous bound for emptying a full queue
   localparam int LIMIT_NS = (3 + RUN_CYCLES + DRAIN_CYCLES) * 10;

   logic clk;
   logic rst;
   logic [ALLOC_SLOTS-1:0] alloc_vld;
   rob_idx_t [ALLOC_SLOTS-1:0] alloc_idx;
   logic flush;
   logic [PTR_W-1:0] flush_ptr;
   logic upd_vld;
   ld_idx_t upd_idx;
   addr_t upd_addr;
   data_t upd_data;
   logic cmmt_str;
   logic str_grnt;
   logic str_done;
   rob_idx_t fwd_idx;
   addr_t fwd_addr;
   logic stall;
   logic str_req;
   logic str_iss;
   addr_t cache_addr;
   data_t cache_data;
   logic fwd_hit;
   logic fwd_rdy;
   data_t fwd_data;

   int unsigned seed;
   int next_idx;        // next reorder index, rising
   logic busy;          // a commit is in flight
   logic issued;        // cache owes a done
   int done_delay;
   logic draining;
   logic req_seen;
   logic iss_seen;
   logic done_seen;

   store_queue #(.DEPTH(DEPTH)) store_queue_i (.*);

   sq_monitor #(.DEPTH(DEPTH)) mon_i (.*);

   function automatic int unsigned next_rand(input int unsigned bound);
      seed = seed * 32'd1103515245 + 32'd12345;
      return (seed >> 8) % bound;
   endfunction

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(LIMIT_NS);
      $display("timeout: the queue did not drain within %0d ns", LIMIT_NS);
      $display("RESULT: FAIL");
      $finish;
   end

   // one cycle: sample outputs at the falling edge, drive at the rising edge
   task automatic step();
      rob_idx_t [ALLOC_SLOTS-1:0] idx_v;
      int n;
      int p;
      @(negedge clk);
      req_seen = str_req;
      iss_seen = str_iss;
      done_seen = str_done;
      @(posedge clk);
      alloc_vld <= '0;
      flush <= 1'b0;
      upd_vld <= 1'b0;
      cmmt_str <= 1'b0;
      str_done <= 1'b0;
      str_grnt <= req_seen && !iss_seen && next_rand(3) == 0; // random grant delay
      if (issued) begin
         if (done_delay == 0) begin
            str_done <= 1'b1;
            issued = 1'b0;
         end else
            done_delay--;
      end
      if (iss_seen) begin
         issued = 1'b1;
         done_delay = next_rand(4);
      end
      if (done_seen)
         busy = 1'b0;
      if (!busy && mon_i.count > 0 && next_rand(draining ? 1 : 4) == 0) begin
         cmmt_str <= 1'b1;
         busy = 1'b1;
      end
      if (mon_i.count > 0 && next_rand(2) == 0) begin
         p = (mon_i.head + next_rand(mon_i.count)) % DEPTH;
         if (!mon_i.m_written[p]) begin
            upd_vld <= 1'b1;
            upd_idx <= ld_idx_t'(mon_i.m_idx[p]);
            upd_addr <= addr_t'(next_rand(8) * 4);
            upd_data <= data_t'(next_rand(65536));
         end
      end
      if (!draining && mon_i.count >= 2 && next_rand(20) == 0) begin
         flush <= 1'b1; // keeps the head, drops at least one store
         flush_ptr <= PTR_W'((mon_i.head + 1 + next_rand(mon_i.count - 1)) % DEPTH);
      end else if (!draining) begin
         n = next_rand(ALLOC_SLOTS + 1);
         if (n > DEPTH - mon_i.count)
            n = DEPTH - mon_i.count;
         if (next_idx + n > 127)
            n = 0;
         idx_v = '0;
         for (int s = 0; s < n; s++)
            idx_v[s] = rob_idx_t'(next_idx + s);
         alloc_idx <= idx_v;
         alloc_vld <= ALLOC_SLOTS'((1 << n) - 1);
         next_idx += n;
      end
      fwd_idx <= rob_idx_t'(next_rand(next_idx + 1));
      fwd_addr <= addr_t'(next_rand(8) * 4);
   endtask

   initial begin
      rst = 1'b0;
      alloc_vld = '0;
      alloc_idx = '0;
      flush = 1'b0;
      flush_ptr = '0;
      upd_vld = 1'b0;
      upd_idx = '0;
      upd_addr = '0;
      upd_data = '0;
      cmmt_str = 1'b0;
      str_grnt = 1'b0;
      str_done = 1'b0;
      fwd_idx = '0;
      fwd_addr = '0;
      seed = 12;
      next_idx = 1;
      busy = 1'b0;
      issued = 1'b0;
      done_delay = 0;
      draining = 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b1;
      repeat (RUN_CYCLES)
         step();
      draining = 1'b1;
      while (mon_i.count != 0 || busy)
         step();
      repeat (2)
         step();
      $display("checks: %0d, errors: %0d, assertion failures: %0d", mon_i.checks,
               mon_i.errors, store_queue_i.commit_ctrl_i.assert_i.fail_cnt);
      if (mon_i.errors == 0 && store_queue_i.commit_ctrl_i.assert_i.fail_cnt == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: files.f
hdl/sq_cfg_pkg.sv
hdl/sq_ctrl_pkg.sv
hdl/sq_entry_if.sv
hdl/sq_entry_array.sv
hdl/sq_commit_ctrl.sv
hdl/sq_fwd_search.sv
hdl/store_queue.sv
sim/sq_assert.sv
sim/sq_monitor.sv
sim/tb_store_queue.sv
